// File: rs5_mem_pkg.sv
// Shared by the memory subsystem only; XLEN is fixed at 32 and the RAM assumes four byte lanes
`default_nettype none

package rs5_mem_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////
    localparam int XLEN = 32;                   // Data and instruction width
    localparam int BE_W = XLEN / 8;             // One enable per byte lane

    //////////////////////////////////////////////////////////////////////
    // Access sizes
    //////////////////////////////////////////////////////////////////////
    // Encoded as log2 of the byte count
    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    //////////////////////////////////////////////////////////////////////
    // Data side operations
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        OP_NONE = 4'd0,                         // Idle cycle
        OP_LB   = 4'd1,                         // Load byte, sign extended
        OP_LH   = 4'd2,                         // Load half, sign extended
        OP_LW   = 4'd3,                         // Load word
        OP_LBU  = 4'd4,                         // Load byte, zero extended
        OP_LHU  = 4'd5,                         // Load half, zero extended
        OP_SB   = 4'd6,                         // Store byte
        OP_SH   = 4'd7,                         // Store half
        OP_SW   = 4'd8                          // Store word
    } mem_op_e;

    // Values 9 to 15 are unused and decode as no access

endpackage

`default_nettype wire

// File: dual_port_ram.sv
// Contents are undefined until written; MEM_BYTES must be a power of two and addresses wrap at the top
`default_nettype none

module dual_port_ram
    import rs5_mem_pkg::*;
#(
    parameter int MEM_BYTES = 4096
)
(
    input  wire logic                           clk,

    // Port A, used for instruction fetch
    input  wire logic                           en_a_i,
    input  wire logic [BE_W-1:0]                we_a_i,
    input  wire logic [$clog2(MEM_BYTES)-1:0]   addr_a_i,
    input  wire logic [XLEN-1:0]                wdata_a_i,
    output logic      [XLEN-1:0]                rdata_a_o,

    // Port B, used for data access
    input  wire logic                           en_b_i,
    input  wire logic [BE_W-1:0]                we_b_i,
    input  wire logic [$clog2(MEM_BYTES)-1:0]   addr_b_i,
    input  wire logic [XLEN-1:0]                wdata_b_i,
    output logic      [XLEN-1:0]                rdata_b_o
);

    localparam int ADDR_W = $clog2(MEM_BYTES);

    logic [7:0] mem [0:MEM_BYTES-1];            // Byte array, no reset

    // Little-endian word starting at any byte address
    function automatic logic [XLEN-1:0] read_word(input logic [ADDR_W-1:0] addr);
        logic [XLEN-1:0] word;
        for (int k = 0; k < BE_W; k++) begin
            word[8*k +: 8] = mem[addr + ADDR_W'(k)];  // Wraps at the end of memory
        end
        return word;
    endfunction

    ///////////////////////////////////////////////////////////////////////
    // Writes
    ///////////////////////////////////////////////////////////////////////
    // Both ports in one block so that port B, written last, wins a collision
    always_ff @(posedge clk) begin
        if (en_a_i) begin
            for (int k = 0; k < BE_W; k++) begin
                if (we_a_i[k]) begin
                    mem[addr_a_i + ADDR_W'(k)] <= wdata_a_i[8*k +: 8];
                end
            end
        end
        if (en_b_i) begin
            for (int k = 0; k < BE_W; k++) begin
                if (we_b_i[k]) begin
                    mem[addr_b_i + ADDR_W'(k)] <= wdata_b_i[8*k +: 8];
                end
            end
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Reads
    ///////////////////////////////////////////////////////////////////////
    // Old byte is seen when the other port writes the same location
    always_ff @(posedge clk) begin
        if (!en_a_i) begin
            rdata_a_o <= '0;                    // Idle port reads zero
        end else if (we_a_i == '0) begin
            rdata_a_o <= read_word(addr_a_i);
        end
        // Write cycle keeps the previous read data
    end

    always_ff @(posedge clk) begin
        if (!en_b_i) begin
            rdata_b_o <= '0;                    // Idle port reads zero
        end else if (we_b_i == '0) begin
            rdata_b_o <= read_word(addr_b_i);
        end
        // Write cycle keeps the previous read data
    end

endmodule

`default_nettype wire

// File: fetch_unit.sv
// RESET_PC and jump targets must be multiples of 4; PC bits above the RAM address width are kept but not decoded
`default_nettype none

module fetch_unit
    import rs5_mem_pkg::*;
#(
    parameter int              MEM_BYTES = 4096,
    parameter logic [XLEN-1:0] RESET_PC  = '0
)
(
    input  wire logic                           clk,
    input  wire logic                           rst_n_i,

    // Control from the core
    input  wire logic                           fetch_en_i,
    input  wire logic                           jump_i,
    input  wire logic [XLEN-1:0]                jump_target_i,

    // RAM port A, read only
    output logic                                ram_en_o,
    output logic      [$clog2(MEM_BYTES)-1:0]   ram_addr_o,
    input  wire logic [XLEN-1:0]                ram_rdata_i,

    // Returned instruction
    output logic      [XLEN-1:0]                instr_o,
    output logic      [XLEN-1:0]                instr_pc_o,
    output logic                                instr_valid_o
);

    localparam int ADDR_W = $clog2(MEM_BYTES);

    logic [XLEN-1:0] pc;                        // Next sequential fetch address
    logic [XLEN-1:0] fetch_addr;                // Address issued this cycle
    logic [XLEN-1:0] inflight_pc;               // Address of the word coming back
    logic            valid_q;

    ///////////////////////////////////////////////////////////////////////
    // Address select
    ///////////////////////////////////////////////////////////////////////
    assign fetch_addr = jump_i ? jump_target_i : pc;  // Jump overrides sequential PC

    assign ram_en_o   = fetch_en_i;
    assign ram_addr_o = fetch_addr[ADDR_W-1:0];

    ///////////////////////////////////////////////////////////////////////
    // PC and in-flight tracking
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            pc      <= RESET_PC;
            valid_q <= 1'b0;
        end else begin
            valid_q <= fetch_en_i;              // One word in flight per enabled cycle
            if (fetch_en_i) begin
                pc <= fetch_addr + XLEN'(4);
            end
            // Jump while stalled is ignored and PC holds
        end
    end

    // Tag for the returning word
    always_ff @(posedge clk) begin
        if (fetch_en_i) begin
            inflight_pc <= fetch_addr;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // Outputs
    ///////////////////////////////////////////////////////////////////////
    assign instr_o       = ram_rdata_i;         // RAM data already registered
    assign instr_pc_o    = inflight_pc;
    assign instr_valid_o = valid_q;

endmodule

`default_nettype wire

// File: load_store_unit.sv
// One request per cycle with no back-pressure; misaligned requests are dropped and address bits above the RAM size are ignored
`default_nettype none

module load_store_unit
    import rs5_mem_pkg::*;
#(
    parameter int MEM_BYTES = 4096
)
(
    input  wire logic                           clk,
    input  wire logic                           rst_n_i,

    // Request from the core
    input  wire mem_op_e                        mem_op_i,
    input  wire logic [XLEN-1:0]                mem_addr_i,
    input  wire logic [XLEN-1:0]                mem_wdata_i,

    // Response to the core
    output logic      [XLEN-1:0]                mem_rdata_o,
    output logic                                mem_rdata_valid_o,
    output logic                                misaligned_o,

    // RAM port B
    output logic                                ram_en_o,
    output logic      [BE_W-1:0]                ram_we_o,
    output logic      [$clog2(MEM_BYTES)-1:0]   ram_addr_o,
    output logic      [XLEN-1:0]                ram_wdata_o,
    input  wire logic [XLEN-1:0]                ram_rdata_i
);

    localparam int ADDR_W = $clog2(MEM_BYTES);

    logic            is_load;
    logic            is_store;
    logic            is_signed;
    logic [1:0]      size;
    logic            misaligned;
    logic            access;                    // Request goes to the RAM
    logic [BE_W-1:0] be_mask;

    logic            load_q;                    // Load response due this cycle
    logic            signed_q;
    logic [1:0]      size_q;

    ///////////////////////////////////////////////////////////////////////
    // Operation decode
    ///////////////////////////////////////////////////////////////////////
    always_comb begin
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_signed = 1'b0;
        size      = SIZE_WORD;
        case (mem_op_i)
            OP_LB:   begin is_load  = 1'b1; is_signed = 1'b1; size = SIZE_BYTE; end
            OP_LH:   begin is_load  = 1'b1; is_signed = 1'b1; size = SIZE_HALF; end
            OP_LW:   begin is_load  = 1'b1; end
            OP_LBU:  begin is_load  = 1'b1; size = SIZE_BYTE; end
            OP_LHU:  begin is_load  = 1'b1; size = SIZE_HALF; end
            OP_SB:   begin is_store = 1'b1; size = SIZE_BYTE; end
            OP_SH:   begin is_store = 1'b1; size = SIZE_HALF; end
            OP_SW:   begin is_store = 1'b1; end
            default: ;                          // OP_NONE and unused codes
        endcase
    end

    // Natural alignment only
    always_comb begin
        case (size)
            SIZE_HALF: misaligned = mem_addr_i[0];
            SIZE_WORD: misaligned = |mem_addr_i[1:0];
            default:   misaligned = 1'b0;
        endcase
    end

    assign misaligned_o = misaligned & (is_load | is_store);
    assign access       = (is_load | is_store) & ~misaligned;

    ///////////////////////////////////////////////////////////////////////
    // RAM request
    ///////////////////////////////////////////////////////////////////////
    always_comb begin
        case (size)
            SIZE_BYTE: be_mask = 4'b0001;
            SIZE_HALF: be_mask = 4'b0011;
            default:   be_mask = 4'b1111;
        endcase
    end

    assign ram_en_o    = access;
    assign ram_we_o    = (access & is_store) ? be_mask : '0;  // Zero mask means read
    assign ram_addr_o  = mem_addr_i[ADDR_W-1:0];
    assign ram_wdata_o = mem_wdata_i;           // Right-justified, RAM offsets by lane

    ///////////////////////////////////////////////////////////////////////
    // Load response
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            load_q <= 1'b0;
        end else begin
            load_q <= access & is_load;
        end
    end

    always_ff @(posedge clk) begin
        if (access & is_load) begin
            signed_q <= is_signed;
            size_q   <= size;
        end
    end

    // Addressed byte sits in the low lane of the returned word
    always_comb begin
        case (size_q)
            SIZE_BYTE: mem_rdata_o = {{(XLEN-8){signed_q & ram_rdata_i[7]}}, ram_rdata_i[7:0]};
            SIZE_HALF: mem_rdata_o = {{(XLEN-16){signed_q & ram_rdata_i[15]}}, ram_rdata_i[15:0]};
            default:   mem_rdata_o = ram_rdata_i;
        endcase
    end

    assign mem_rdata_valid_o = load_q;

endmodule

`default_nettype wire

// File: mem_subsystem_top.sv
// Simulation memory only; RAM starts undefined and port A is read-only instruction fetch
`default_nettype none

module mem_subsystem_top
    import rs5_mem_pkg::*;
#(
    parameter int              MEM_BYTES = 4096,
    parameter logic [XLEN-1:0] RESET_PC  = '0
)
(
    input  wire logic            clk,
    input  wire logic            rst_n_i,

    // Fetch side
    input  wire logic            fetch_en_i,
    input  wire logic            jump_i,
    input  wire logic [XLEN-1:0] jump_target_i,
    output logic      [XLEN-1:0] instr_o,
    output logic      [XLEN-1:0] instr_pc_o,
    output logic                 instr_valid_o,

    // Data side
    input  wire mem_op_e         mem_op_i,
    input  wire logic [XLEN-1:0] mem_addr_i,
    input  wire logic [XLEN-1:0] mem_wdata_i,
    output logic      [XLEN-1:0] mem_rdata_o,
    output logic                 mem_rdata_valid_o,
    output logic                 misaligned_o
);

    localparam int ADDR_W = $clog2(MEM_BYTES);

    //////////////////////////////////////////////////////////////////////
    // Port A wires
    //////////////////////////////////////////////////////////////////////
    logic              en_a;
    logic [BE_W-1:0]   we_a;
    logic [ADDR_W-1:0] addr_a;
    logic [XLEN-1:0]   wdata_a;
    logic [XLEN-1:0]   rdata_a;

    assign we_a    = '0;                        // Fetch never writes
    assign wdata_a = '0;

    //////////////////////////////////////////////////////////////////////
    // Port B wires
    //////////////////////////////////////////////////////////////////////
    logic              en_b;
    logic [BE_W-1:0]   we_b;
    logic [ADDR_W-1:0] addr_b;
    logic [XLEN-1:0]   wdata_b;
    logic [XLEN-1:0]   rdata_b;

    fetch_unit #(.MEM_BYTES(MEM_BYTES), .RESET_PC(RESET_PC)) fetch0 (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .fetch_en_i    (fetch_en_i),
        .jump_i        (jump_i),
        .jump_target_i (jump_target_i),
        .ram_en_o      (en_a),
        .ram_addr_o    (addr_a),
        .ram_rdata_i   (rdata_a),
        .instr_o       (instr_o),
        .instr_pc_o    (instr_pc_o),
        .instr_valid_o (instr_valid_o)
    );

    load_store_unit #(.MEM_BYTES(MEM_BYTES)) lsu0 (
        .clk               (clk),
        .rst_n_i           (rst_n_i),
        .mem_op_i          (mem_op_i),
        .mem_addr_i        (mem_addr_i),
        .mem_wdata_i       (mem_wdata_i),
        .mem_rdata_o       (mem_rdata_o),
        .mem_rdata_valid_o (mem_rdata_valid_o),
        .misaligned_o      (misaligned_o),
        .ram_en_o          (en_b),
        .ram_we_o          (we_b),
        .ram_addr_o        (addr_b),
        .ram_wdata_o       (wdata_b),
        .ram_rdata_i       (rdata_b)
    );

    dual_port_ram #(.MEM_BYTES(MEM_BYTES)) ram0 (
        .clk       (clk),
        .en_a_i    (en_a),
        .we_a_i    (we_a),
        .addr_a_i  (addr_a),
        .wdata_a_i (wdata_a),
        .rdata_a_o (rdata_a),
        .en_b_i    (en_b),
        .we_b_i    (we_b),
        .addr_b_i  (addr_b),
        .wdata_b_i (wdata_b),
        .rdata_b_o (rdata_b)
    );

endmodule

`default_nettype wire

// File: mem_subsystem_asserts.sv
// Bound into mem_subsystem_top; checks port usage only, RAM contents are left to the testbench
`default_nettype none

module mem_subsystem_asserts
    import rs5_mem_pkg::*;
(
    input wire logic            clk,
    input wire logic            rst_n_i,
    input wire logic [BE_W-1:0] we_a_i,
    input wire logic            en_b_i,
    input wire mem_op_e         mem_op_i,
    input wire logic            misaligned_i,
    input wire logic            rdata_valid_i,
    input wire logic            instr_valid_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int   fail_count = 0;                       // Read by the testbench
    logic load_req;                             // Aligned load out of reset

    assign load_req = rst_n_i && !misaligned_i &&
                      (mem_op_i inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU});

    ///////////////////////////////////////////////////////////////////////
    // Port rules
    ///////////////////////////////////////////////////////////////////////
    fetch_read_only: assert property (@(posedge clk) we_a_i == '0)
        else begin $error("port A write enable set"); fail_count++; end

    // Load response exactly one cycle later, never without a load
    load_gives_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        load_req |=> rdata_valid_i)
        else begin $error("load without response"); fail_count++; end
    valid_needs_load: assert property (@(posedge clk) disable iff (!rst_n_i)
        rdata_valid_i |-> $past(load_req))
        else begin $error("response without load"); fail_count++; end

    misaligned_no_access: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(misaligned_i && en_b_i))
        else begin $error("misaligned request reached the RAM"); fail_count++; end

    reset_no_fetch: assert property (@(posedge clk) !rst_n_i |=> !instr_valid_i)
        else begin $error("instruction valid during reset"); fail_count++; end

endmodule

bind mem_subsystem_top mem_subsystem_asserts asserts0 (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .we_a_i        (we_a),
    .en_b_i        (en_b),
    .mem_op_i      (mem_op_i),
    .misaligned_i  (misaligned_o),
    .rdata_valid_i (mem_rdata_valid_o),
    .instr_valid_i (instr_valid_o)
);

`default_nettype wire

// File: tb_mem_subsystem.sv
// Runs the default 4 KiB RAM with RESET_PC 0; every address that is read back must be written first
`default_nettype none

module tb_mem_subsystem
    import rs5_mem_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int              MEM_BYTES = 4096;
    localparam logic [XLEN-1:0] RESET_PC  = 32'h0;
    localparam logic [XLEN-1:0] JUMP_PC   = 32'h400;    // Second code block for the jump test
    localparam logic [31:0]     LFSR_TAPS = 32'h80200003;

    logic            clk;
    logic            rst_n_i;
    logic            fetch_en_i;
    logic            jump_i;
    logic [XLEN-1:0] jump_target_i;
    logic [XLEN-1:0] instr_o;
    logic [XLEN-1:0] instr_pc_o;
    logic            instr_valid_o;
    mem_op_e         mem_op_i;
    logic [XLEN-1:0] mem_addr_i;
    logic [XLEN-1:0] mem_wdata_i;
    logic [XLEN-1:0] mem_rdata_o;
    logic            mem_rdata_valid_o;
    logic            misaligned_o;

    // Stimulus table, one entry per cycle
    mem_op_e         t_op[$];
    logic [XLEN-1:0] t_addr[$], t_wdata[$], t_tgt[$];
    logic            t_fen[$], t_jmp[$];
    // Expected values, seen one cycle later except t_mis
    logic            t_mis[$], t_ld[$], t_iv[$];
    logic [XLEN-1:0] t_rdata[$], t_ipc[$], t_instr[$];
    int              t_test[$];

    logic [7:0]      model [0:MEM_BYTES-1];     // Byte model of the RAM
    logic [XLEN-1:0] model_pc = RESET_PC;       // Fetch PC model
    logic [31:0]     lfsr_state = 32'hd053;
    int              checks = 0;
    int              errors = 0;
    int              test_errs = 0;
    int              tests_run = 0;
    int              watchdog_cycles;

    mem_subsystem_top #(.MEM_BYTES(MEM_BYTES), .RESET_PC(RESET_PC)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                 // 20 ns period
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////
    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int b = 0; b < n; b++) begin
            val[b]     = lfsr_state[0];
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? LFSR_TAPS : 32'h0);
        end
        return val;
    endfunction

    function automatic logic is_load(input mem_op_e op);
        return op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
    endfunction

    function automatic logic is_store(input mem_op_e op);
        return op inside {OP_SB, OP_SH, OP_SW};
    endfunction

    function automatic int op_bytes(input mem_op_e op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return 1;
            OP_LH, OP_LHU, OP_SH: return 2;
            default:              return 4;
        endcase
    endfunction

    // Little-endian word from the model, wrapping at the top
    function automatic logic [XLEN-1:0] read_model(input logic [XLEN-1:0] addr);
        logic [XLEN-1:0] word;
        for (int k = 0; k < 4; k++) begin
            word[8*k +: 8] = model[(addr + k) % MEM_BYTES];
        end
        return word;
    endfunction

    function automatic string test_name(input int id);
        case (id)
            0:       return "word store and load";
            1:       return "byte and half extension";
            2:       return "misaligned access";
            3:       return "fetch from reset pc";
            4:       return "jump and fetch stop";
            default: return "back-to-back loads";
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Table build with the reference model
    //////////////////////////////////////////////////////////////////////
    task automatic add_entry(input int test, input mem_op_e op, input logic [XLEN-1:0] addr,
                             input logic [XLEN-1:0] wdata, input logic fen, input logic jmp,
                             input logic [XLEN-1:0] tgt);
        logic            mis;
        logic [XLEN-1:0] faddr;
        logic [XLEN-1:0] word;
        mis   = (is_load(op) || is_store(op)) && (addr % op_bytes(op) != 0);
        faddr = jmp ? tgt : model_pc;           // Jump wins over sequential PC
        if (fen) begin
            model_pc = faddr + 4;               // Stalled PC holds, jump ignored
        end
        word = read_model(addr);
        case (op)
            OP_LB:   word = {{24{word[7]}}, word[7:0]};
            OP_LBU:  word = {24'h0, word[7:0]};
            OP_LH:   word = {{16{word[15]}}, word[15:0]};
            OP_LHU:  word = {16'h0, word[15:0]};
            default: ;
        endcase
        t_test.push_back(test);
        t_op.push_back(op);
        t_addr.push_back(addr);
        t_wdata.push_back(wdata);
        t_fen.push_back(fen);
        t_jmp.push_back(jmp);
        t_tgt.push_back(tgt);
        t_mis.push_back(mis);
        t_ld.push_back(is_load(op) && !mis);
        t_rdata.push_back(word);
        t_iv.push_back(fen);
        t_ipc.push_back(faddr);
        t_instr.push_back(read_model(faddr));   // Read before this entry's store
        if (is_store(op) && !mis) begin
            for (int k = 0; k < op_bytes(op); k++) begin
                model[(addr + k) % MEM_BYTES] = wdata[8*k +: 8];
            end
        end
    endtask

    task automatic data_op(input int test, input mem_op_e op, input logic [XLEN-1:0] addr,
                           input logic [XLEN-1:0] wdata);
        add_entry(test, op, addr, wdata, 1'b0, 1'b0, '0);
    endtask

    task automatic fetch_cycle(input int test, input logic en, input logic jmp,
                               input logic [XLEN-1:0] tgt);
        add_entry(test, OP_NONE, '0, '0, en, jmp, tgt);
    endtask

    task automatic build_table();
        data_op(0, OP_SW, 32'h100, rand_bits(32));
        data_op(0, OP_LW, 32'h100, '0);         // Load right after the store
        data_op(0, OP_SW, 32'h104, rand_bits(32));
        data_op(0, OP_NONE, '0, '0);
        data_op(0, OP_LW, 32'h104, '0);
        data_op(1, OP_SW, 32'h200, rand_bits(32));
        data_op(1, OP_SB, 32'h201, 32'h80);     // Sign bit set
        data_op(1, OP_SH, 32'h202, 32'hffff8123);
        data_op(1, OP_LW, 32'h200, '0);         // Only the stored lanes changed
        data_op(1, OP_LB, 32'h201, '0);
        data_op(1, OP_LBU, 32'h201, '0);
        data_op(1, OP_LH, 32'h202, '0);
        data_op(1, OP_LHU, 32'h202, '0);
        data_op(1, OP_SB, 32'h200, rand_bits(8));
        data_op(1, OP_LB, 32'h200, '0);
        data_op(1, OP_LBU, 32'h200, '0);
        data_op(2, OP_SW, 32'h300, rand_bits(32));
        data_op(2, OP_LH, 32'h301, '0);
        data_op(2, OP_LW, 32'h302, '0);
        data_op(2, OP_SH, 32'h303, 32'hbeef);
        data_op(2, OP_SW, 32'h301, 32'hdeadbeef);
        data_op(2, OP_LW, 32'h300, '0);         // Confirms memory untouched
        data_op(5, OP_LB, 32'h200, '0);         // Loads every cycle
        data_op(5, OP_LHU, 32'h202, '0);
        data_op(5, OP_LW, 32'h100, '0);
        data_op(5, OP_LBU, 32'h203, '0);
        data_op(5, OP_LH, 32'h200, '0);
        data_op(5, OP_LB, 32'h203, '0);
        // Code for the fetch tests
        for (int k = 0; k < 8; k++) data_op(3, OP_SW, RESET_PC + 4 * k, rand_bits(32));
        for (int k = 0; k < 4; k++) data_op(3, OP_SW, JUMP_PC + 4 * k, rand_bits(32));
        for (int k = 0; k < 6; k++) fetch_cycle(3, 1'b1, 1'b0, '0);
        fetch_cycle(4, 1'b1, 1'b1, JUMP_PC);
        fetch_cycle(4, 1'b1, 1'b0, '0);
        fetch_cycle(4, 1'b0, 1'b0, '0);
        fetch_cycle(4, 1'b0, 1'b1, RESET_PC);   // Ignored while stalled
        fetch_cycle(4, 1'b1, 1'b0, '0);         // Resumes at JUMP_PC + 8
        fetch_cycle(4, 1'b1, 1'b0, '0);
        fetch_cycle(4, 1'b0, 1'b0, '0);
        fetch_cycle(4, 1'b0, 1'b0, '0);         // Trailing idle
    endtask

    //////////////////////////////////////////////////////////////////////
    // Drive and check
    //////////////////////////////////////////////////////////////////////
    task automatic check_value(input string what, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errs++;
            $display("error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_response(input int p);
        check_value("load valid", mem_rdata_valid_o, t_ld[p]);
        if (t_ld[p]) check_value("load data", mem_rdata_o, t_rdata[p]);
        check_value("instr valid", instr_valid_o, t_iv[p]);
        if (t_iv[p]) begin
            check_value("instr pc", instr_pc_o, t_ipc[p]);
            check_value("instr word", instr_o, t_instr[p]);
        end
    endtask

    task automatic report_test(input int id);
        $display("test %0d %s: %0d errors", id, test_name(id), test_errs);
        tests_run++;
        test_errs = 0;
    endtask

    initial begin
        rst_n_i       = 1'b0;
        fetch_en_i    = 1'b1;                   // Fetch requested in reset, must stay idle
        jump_i        = 1'b0;
        jump_target_i = '0;
        mem_op_i      = OP_NONE;
        mem_addr_i    = '0;
        mem_wdata_i   = '0;
        build_table();
        repeat (8) @(posedge clk);
        #2;
        rst_n_i    = 1'b1;
        fetch_en_i = 1'b0;
        for (int i = 0; i < t_op.size(); i++) begin
            @(posedge clk);
            #2;                                 // Drive clear of the edge
            mem_op_i      = t_op[i];
            mem_addr_i    = t_addr[i];
            mem_wdata_i   = t_wdata[i];
            fetch_en_i    = t_fen[i];
            jump_i        = t_jmp[i];
            jump_target_i = t_tgt[i];
            @(negedge clk);                     // Outputs settled mid-cycle
            if (i > 0) begin
                check_response(i - 1);
                if (t_test[i] != t_test[i - 1]) report_test(t_test[i - 1]);
            end
            check_value("misaligned", misaligned_o, t_mis[i]);
        end
        report_test(t_test[t_op.size() - 1]);
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests_run, checks, errors, dut0.asserts0.fail_count);
        if (errors == 0 && dut0.asserts0.fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Watchdog sized from the table once it is built
    initial begin
        #1;
        watchdog_cycles = t_op.size() * 20 + 100;
        #(watchdog_cycles * 20);
        $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
rs5_mem_pkg.sv
dual_port_ram.sv
fetch_unit.sv
load_store_unit.sv
mem_subsystem_top.sv
mem_subsystem_asserts.sv
tb_mem_subsystem.sv

// File: Bender.yml
package:
  name: mem_subsystem

sources:
  - rs5_mem_pkg.sv
  - dual_port_ram.sv
  - fetch_unit.sv
  - load_store_unit.sv
  - mem_subsystem_top.sv
  - target: test
    files:
      - mem_subsystem_asserts.sv
      - tb_mem_subsystem.sv
